//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

	////////////////////////////////////////////////////////////
	// datapath width
	////////////////////////////////////////////////////////////

	localparam int XLEN = 32;

	////////////////////////////////////////////////////////////
	// decode -> execute
	////////////////////////////////////////////////////////////

	typedef struct packed {
		isa_pkg::op_type_e op;
		isa_pkg::alu_op_e  alu;
		logic [4:0]        rd;
		logic [4:0]        rs1;
		logic [4:0]        rs2;
		// already sign extended and shifted for its format
		logic [XLEN-1:0]   imm;
	} decoded_t;

	////////////////////////////////////////////////////////////
	// retire record
	////////////////////////////////////////////////////////////

	// also drives the register file write port
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic            wen;
		logic [4:0]      rd;
		logic [XLEN-1:0] wdata;
	} retire_t;

endpackage

`default_nettype wire

//--- design/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
	input  logic [31:0]        instr,
	output core_pkg::decoded_t dec
);

	import isa_pkg::*;
	import core_pkg::*;

	rv_instr_t        f;
	op_type_e         op;
	alu_op_e          alu;
	logic [XLEN-1:0]  imm_i;
	logic [XLEN-1:0]  imm_u;
	logic [XLEN-1:0]  imm_j;
	logic [XLEN-1:0]  imm;

	assign f = instr;

	////////////////////////////////////////////////////////////
	// instruction class
	////////////////////////////////////////////////////////////

	always_comb begin
		case (f.opcode)
			OPC_OP:     op = OP_R;
			OPC_OP_IMM: op = OP_I;
			OPC_LUI:    op = OP_U;
			OPC_AUIPC:  op = OP_UPC;
			OPC_JAL:    op = OP_J;
			OPC_JALR:   op = OP_JR;
			// anything else retires as a no-op
			default:    op = OP_NONE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// immediates
	////////////////////////////////////////////////////////////

	// i-type, also jalr
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	// upper 20 bits, low 12 zero
	assign imm_u = {instr[31:12], 12'b0};
	// jal offset, bit 0 always zero
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (op)
			OP_I, OP_JR:  imm = imm_i;
			OP_U, OP_UPC: imm = imm_u;
			OP_J:         imm = imm_j;
			// r-type and no-op carry no immediate
			default:      imm = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// alu operation
	////////////////////////////////////////////////////////////

	always_comb begin
		case (f.funct3)
			// funct7[5] selects sub, r-type only
			F3_ADDSUB: alu = (op == OP_R && f.funct7[5]) ? ALU_SUB : ALU_ADD;
			F3_XOR:    alu = ALU_XOR;
			F3_OR:     alu = ALU_OR;
			F3_AND:    alu = ALU_AND;
			default:   alu = ALU_ADD;
		endcase
	end

	assign dec.op  = op;
	assign dec.alu = alu;
	assign dec.rd  = f.rd;
	assign dec.rs1 = f.rs1;
	assign dec.rs2 = f.rs2;
	assign dec.imm = imm;

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
	input  logic [core_pkg::XLEN-1:0] pc,
	input  core_pkg::decoded_t        dec,
	input  logic [core_pkg::XLEN-1:0] rdata1,
	input  logic [core_pkg::XLEN-1:0] rdata2,
	output core_pkg::retire_t         ret,
	output logic [core_pkg::XLEN-1:0] npc
);

	import isa_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] snpc;
	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] res;
	logic [XLEN-1:0] jr_sum;
	alu_op_e         alu;

	// sequential next pc, also the link value
	assign snpc = pc + XLEN'(4);

	////////////////////////////////////////////////////////////
	// operand select
	////////////////////////////////////////////////////////////

	always_comb begin
		case (dec.op)
			OP_R, OP_I:  opa = rdata1;
			OP_U:        opa = dec.imm;
			OP_UPC:      opa = pc;
			OP_J, OP_JR: opa = snpc;
			default:     opa = '0;
		endcase
	end

	always_comb begin
		case (dec.op)
			OP_R:         opb = rdata2;
			OP_I, OP_UPC: opb = dec.imm;
			// lui and jumps pass opa through
			default:      opb = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	// funct3 is only meaningful for r and i
	// lui, auipc and jumps all need a plain add
	assign alu = (dec.op == OP_R || dec.op == OP_I) ? dec.alu : ALU_ADD;

	always_comb begin
		case (alu)
			ALU_SUB: res = opa - opb;
			ALU_XOR: res = opa ^ opb;
			ALU_AND: res = opa & opb;
			ALU_OR:  res = opa | opb;
			default: res = opa + opb;
		endcase
	end

	////////////////////////////////////////////////////////////
	// retire and next pc
	////////////////////////////////////////////////////////////

	assign ret.pc    = pc;
	assign ret.wen   = (dec.op != OP_NONE);
	assign ret.rd    = dec.rd;
	assign ret.wdata = res;

	// jalr target, low bit forced to zero
	assign jr_sum = rdata1 + dec.imm;

	always_comb begin
		case (dec.op)
			OP_J:    npc = pc + dec.imm;
			OP_JR:   npc = {jr_sum[XLEN-1:1], 1'b0};
			default: npc = snpc;
		endcase
	end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [core_pkg::XLEN-1:0]     npc,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  logic [31:0]                   imem_wdata,
	output logic [core_pkg::XLEN-1:0]     pc,
	output logic [31:0]                   instr
);

	// word address width of the memory
	localparam int AW = $clog2(IMEM_DEPTH);

	////////////////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////////////////

	// held at 0 through reset, then one step per edge
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= npc;
		end
	end

	////////////////////////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////////////////////////

	logic [31:0]   imem [IMEM_DEPTH];
	logic [AW-1:0] fetch_idx;

	// program load port, one word per edge
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// word index, upper pc bits dropped
	// so the program wraps around the depth
	assign fetch_idx = pc[AW+1:2];

	// async read, same cycle as pc
	assign instr = imem[fetch_idx];

endmodule

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

	////////////////////////////////////////////////////////////
	// opcodes of the supported subset
	////////////////////////////////////////////////////////////

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// funct3 for the alu group, shared by op and op-imm
	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;

	////////////////////////////////////////////////////////////
	// decoded classes and alu operations
	////////////////////////////////////////////////////////////

	// instruction class, picks operands and next pc
	typedef enum logic [2:0] {
		OP_R,
		OP_I,
		OP_U,
		OP_UPC,
		OP_J,
		OP_JR,
		OP_NONE
	} op_type_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_AND,
		ALU_OR
	} alu_op_e;

	// raw field split, r-type layout
	// other formats reuse the same bit positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_instr_t;

endpackage

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [4:0]                raddr1,
	input  logic [4:0]                raddr2,
	output logic [core_pkg::XLEN-1:0] rdata1,
	output logic [core_pkg::XLEN-1:0] rdata2,
	input  logic                      wen,
	input  logic [4:0]                waddr,
	input  logic [core_pkg::XLEN-1:0] wdata
);

	import core_pkg::*;

	logic [XLEN-1:0] regs [32];

	// whole file cleared so a fresh program sees zeros
	// x0 is never written after that and keeps reading zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// combinational reads with no bypass so a write shows up next cycle
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- design/riscv_core.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  logic [31:0]                   imem_wdata,
	output logic                          retire_valid,
	output core_pkg::retire_t             retire
);

	import core_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] npc;
	logic [31:0]     instr;
	decoded_t        dec;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;

	////////////////////////////////////////////////////////////
	// front end
	////////////////////////////////////////////////////////////

	fetch_unit #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) fetch_unit_inst (
		.clk       (clk),
		.rst       (rst),
		.npc       (npc),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_wdata(imem_wdata),
		.pc        (pc),
		.instr     (instr)
	);

	decode_unit decode_unit_inst (
		.instr(instr),
		.dec  (dec)
	);

	////////////////////////////////////////////////////////////
	// registers and execute
	////////////////////////////////////////////////////////////

	// write port fed straight from the retire record
	reg_file reg_file_inst (
		.clk   (clk),
		.rst   (rst),
		.raddr1(dec.rs1),
		.raddr2(dec.rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wen   (retire.wen),
		.waddr (retire.rd),
		.wdata (retire.wdata)
	);

	exec_unit exec_unit_inst (
		.pc    (pc),
		.dec   (dec),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.ret   (retire),
		.npc   (npc)
	);

	// one instruction every cycle out of reset
	assign retire_valid = !rst;

endmodule

`default_nettype wire

//--- sim/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int IMEM_DEPTH = 256;
	localparam int AW = $clog2(IMEM_DEPTH);
	localparam int PROG_LEN = 200;
	localparam logic [31:0] END_PC = 32'(PROG_LEN * 4);

	logic          clk = 1'b0;
	logic          rst;
	logic          imem_we;
	logic [AW-1:0] imem_addr;
	logic [31:0]   imem_wdata;
	logic          retire_valid;
	retire_t       retire;

	logic [31:0] prog [IMEM_DEPTH];
	logic [31:0] ref_regs [32];
	logic [31:0] ref_pc;
	logic [31:0] rng = 32'h07c6_5a24;
	int          nop_idx;
	int          steps;
	int          limit;
	int          cycles = 0;
	logic        loaded = 1'b0;
	logic        running = 1'b0;
	logic        done = 1'b0;
	int          checks [5];
	int          errors [5];
	string       test_names [5] = '{"reset", "alu", "upper", "jump", "x0_nop"};

	riscv_core #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) riscv_core_inst (
		.clk         (clk),
		.rst         (rst),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.retire_valid(retire_valid),
		.retire      (retire)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// byte offset, bit 0 dropped by the format
	function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// a jump from i to t must not skip the unsupported word
	function automatic logic crosses(int i, int t);
		return i <= nop_idx && t > nop_idx;
	endfunction

	function automatic logic [31:0] random_op(logic [4:0] rd);
		logic [31:0] q;
		logic [2:0]  f3;
		q = next_rand();
		case (q[5:4])
			2'd0:    f3 = F3_ADDSUB;
			2'd1:    f3 = F3_XOR;
			2'd2:    f3 = F3_OR;
			default: f3 = F3_AND;
		endcase
		case (q[2:0])
			// sub only with the add/sub funct3
			3'd0, 3'd1, 3'd2:
				return enc_r({1'b0, q[16] && f3 == F3_ADDSUB, 5'b0}, q[15:11], q[10:6], f3, rd);
			3'd3, 3'd4, 3'd5:
				return enc_i(q[31:20], q[10:6], f3, rd, OPC_OP_IMM);
			3'd6:    return enc_u(q[31:12], rd, OPC_LUI);
			default: return enc_u(q[31:12], rd, OPC_AUIPC);
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// program generation
	////////////////////////////////////////////////////////////

	task automatic gen_program();
		int          i;
		int          t;
		int          sel;
		logic [31:0] r;
		logic [4:0]  rd;
		logic [31:0] off;
		logic [31:0] base;
		logic [31:0] hi;
		logic        is_target [PROG_LEN];
		foreach (is_target[k]) is_target[k] = 1'b0;
		nop_idx = 40 + int'(next_rand() % 32'd120);
		i = 0;
		while (i < PROG_LEN) begin
			r = next_rand();
			sel = int'(r[7:0] % 8'd20);
			// x31 kept for jalr bases
			rd = r[12:8] % 5'd31;
			t = i + 2 + int'(r[14:13]);
			if (i == nop_idx) begin
				// load opcode, not in the subset
				prog[i] = {r[31:7], 7'b0000011};
				i++;
			end else if (sel == 0 && t < PROG_LEN && !crosses(i, t)) begin
				prog[i] = enc_j(21'((t - i) * 4), rd);
				is_target[t] = 1'b1;
				i++;
			end else if (sel == 1 && t + 1 < PROG_LEN && !crosses(i, t + 1) &&
					!is_target[i + 1] && !is_target[i + 2]) begin
				// lui/addi build x31, jalr lands on word t+1
				// odd sums check the cleared bit 0
				off = {{28{r[21]}}, r[21:18]};
				base = 32'((t + 1) * 4) + 32'(r[17]) - off;
				hi = (base + 32'h800) >> 12;
				prog[i] = enc_u(hi[19:0], 5'd31, OPC_LUI);
				prog[i + 1] = enc_i(base[11:0], 5'd31, F3_ADDSUB, 5'd31, OPC_OP_IMM);
				prog[i + 2] = enc_i(off[11:0], 5'd31, 3'b000, rd, OPC_JALR);
				is_target[t + 1] = 1'b1;
				i += 3;
			end else begin
				prog[i] = random_op(rd);
				i++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			F3_ADDSUB: return sub ? a - b : a + b;
			F3_XOR:    return a ^ b;
			F3_OR:     return a | b;
			F3_AND:    return a & b;
			default:   return a + b;
		endcase
	endfunction

	task automatic ref_reset();
		ref_pc = '0;
		foreach (ref_regs[k]) ref_regs[k] = '0;
	endtask

	// one instruction on the model state, returns its retire record
	function automatic retire_t ref_step();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] npc;
		retire_t     r;
		ins = prog[ref_pc[AW+1:2]];
		a = ref_regs[ins[19:15]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_u = {ins[31:12], 12'b0};
		r.pc = ref_pc;
		r.wen = 1'b1;
		r.rd = ins[11:7];
		r.wdata = '0;
		npc = ref_pc + 32'd4;
		case (ins[6:0])
			OPC_OP:     r.wdata = alu_ref(ins[14:12], ins[30], a, ref_regs[ins[24:20]]);
			OPC_OP_IMM: r.wdata = alu_ref(ins[14:12], 1'b0, a, imm_i);
			OPC_LUI:    r.wdata = imm_u;
			OPC_AUIPC:  r.wdata = ref_pc + imm_u;
			OPC_JAL: begin
				r.wdata = ref_pc + 32'd4;
				npc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			OPC_JALR: begin
				r.wdata = ref_pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			default:    r.wen = 1'b0;
		endcase
		if (r.wen && r.rd != 5'd0) ref_regs[r.rd] = r.wdata;
		ref_pc = npc;
		return r;
	endfunction

	function automatic int test_of(logic [31:0] ins);
		case (ins[6:0])
			OPC_JAL, OPC_JALR: return 3;
			OPC_OP, OPC_OP_IMM: return (ins[11:7] == 5'd0) ? 4 : 1;
			OPC_LUI, OPC_AUIPC: return (ins[11:7] == 5'd0) ? 4 : 2;
			default: return 4;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// checker
	////////////////////////////////////////////////////////////

	task automatic check_field(int t, string field, logic [31:0] exp_v, logic [31:0] act_v);
		checks[t]++;
		assert (act_v === exp_v) else begin
			$display("ERROR test=%s field=%s expected=%h actual=%h",
				test_names[t], field, exp_v, act_v);
			errors[t]++;
		end
	endtask

	// outputs sampled at the rising edge, before the commit
	always @(posedge clk) begin
		retire_t exp;
		int      t;
		if (loaded && rst) begin
			check_field(0, "retire_valid", 32'd0, 32'(retire_valid));
		end else if (running && !done) begin
			t = test_of(prog[ref_pc[AW+1:2]]);
			exp = ref_step();
			check_field(t, "retire_valid", 32'd1, 32'(retire_valid));
			check_field(t, "pc", exp.pc, retire.pc);
			check_field(t, "wen", 32'(exp.wen), 32'(retire.wen));
			if (exp.wen) begin
				check_field(t, "rd", 32'(exp.rd), 32'(retire.rd));
				check_field(t, "wdata", exp.wdata, retire.wdata);
			end
			if (ref_pc >= END_PC) done = 1'b1;
		end
	end

	// limit counts reset, program steps and some slack
	always @(posedge clk) begin
		if (loaded) begin
			cycles++;
			if (cycles > limit) begin
				$display("timeout after %0d cycles, the core never reached the program end",
					cycles);
				$display("SOME TESTS FAILED");
				$finish;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int total_c;
		int total_e;
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		total_c = 0;
		total_e = 0;
		foreach (checks[k]) checks[k] = 0;
		foreach (errors[k]) errors[k] = 0;
		gen_program();
		// dry run of the model for the step count
		ref_reset();
		steps = 0;
		while (ref_pc < END_PC && steps < 1000) begin
			void'(ref_step());
			steps++;
		end
		limit = 3 + steps + 50;
		ref_reset();
		// load through the imem port, rst held high
		for (int i = 0; i < PROG_LEN; i++) begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = AW'(i);
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		loaded = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		running = 1'b1;
		wait (done);
		for (int t = 0; t < 5; t++) begin
			if (checks[t] == 0) begin
				$display("test %s was never exercised by the program", test_names[t]);
				errors[t]++;
			end
			$display("test %-7s %0d checks, %0d errors", test_names[t], checks[t], errors[t]);
			total_c += checks[t];
			total_e += errors[t];
		end
		$display("%0d steps, %0d checks, %0d errors", steps, total_c, total_e);
		if (total_e == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/riscv_core.sv
sim/core_tb.sv
